// File: source/mlc_defines.svh
`ifndef MLC_DEFINES_SVH
`define MLC_DEFINES_SVH

// serial bit time in clock cycles
`define CLKS_PER_BIT 16

// idle bit times before a partial frame is thrown away
`define FRAME_GAP_BITS 25

// trigger pulse shape
`define PULSE_ON_CLKS 40
`define PULSE_OFF_CLKS 32

// trigger and vector channels
`define N_CH 4

`endif

// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// one byte on the serial line
	typedef logic [7:0] uart_byte_t;

	// receiver output, valid for one cycle per good byte
	typedef struct packed {
		logic       valid;
		uart_byte_t data;
	} rx_beat_t;

endpackage

`default_nettype wire

// File: source/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	typedef enum logic [7:0] {
		CMD_RD_VEC   = 8'h00,
		CMD_SET_TRIG = 8'h53,
		CMD_FIRE     = 8'h5C,
		CMD_WR_VEC   = 8'hA5
	} cmd_code_e;

	typedef enum logic [1:0] {
		TRIG_HIGH = 2'd1, // idle low, pulses high
		TRIG_LOW  = 2'd2
	} trig_mode_e;

	typedef struct packed {
		trig_mode_e mode;
		logic [7:0] count;
	} trig_cfg_t;

	// byte 0 sits in the low bits
	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] value;
		logic [7:0] ch;
		cmd_code_e  cmd;
	} vec_view_t;

	typedef struct packed {
		logic [7:0] count;
		logic [7:0] mode;
		logic [7:0] ch;
		cmd_code_e  cmd;
	} trig_view_t;

	typedef union packed {
		vec_view_t  vec;
		trig_view_t trig;
	} cmd_frame_u;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module uart_rx (
	input  logic               clk,
	input  logic               nrst,
	input  logic               rxd,
	output uart_pkg::rx_beat_t beat
);
	localparam int CW = $clog2(`CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST  = CW'(`CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_LAST = CW'(`CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e state;
	logic [1:0] rx_sync;
	logic rxd_s;
	logic [CW-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;

	assign rxd_s = rx_sync[1];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rx_sync <= 2'b11; // line idles high
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			beat <= '0;
		end else begin
			rx_sync <= {rx_sync[0], rxd};
			beat.valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rxd_s)
						state <= RX_START;
				end
				RX_START: begin
					cnt <= cnt + 1'b1;
					if (cnt == HALF_LAST) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rxd_s ? RX_IDLE : RX_DATA; // glitch, not a start bit
					end
				end
				RX_DATA: begin
					cnt <= cnt + 1'b1;
					if (cnt == BIT_LAST) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				default: begin
					cnt <= cnt + 1'b1;
					if (cnt == BIT_LAST) begin
						state <= RX_IDLE;
						beat.valid <= rxd_s; // framing error drops the byte
						beat.data <= shreg;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && cnt == BIT_LAST)
			shreg <= {rxd_s, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: source/frame_assembler.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module frame_assembler (
	input  logic                clk,
	input  logic                nrst,
	input  uart_pkg::rx_beat_t  beat,
	output logic                frame_req,
	output cmd_pkg::cmd_frame_u frame,
	input  logic                frame_ack
);
	localparam int GAP_CLKS = `FRAME_GAP_BITS * `CLKS_PER_BIT;
	localparam int GW = $clog2(GAP_CLKS);
	localparam logic [GW-1:0] GAP_LAST = GW'(GAP_CLKS - 1);

	logic [1:0] pos;
	logic [GW-1:0] gap_cnt;
	logic [31:0] frame_bits;
	logic take;

	// no room while the engine still owns the last frame
	assign take = beat.valid && !frame_req && !frame_ack;
	assign frame = frame_bits;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			pos <= '0;
			gap_cnt <= '0;
			frame_req <= 1'b0;
		end else begin
			if (frame_req && frame_ack)
				frame_req <= 1'b0;
			if (take) begin
				gap_cnt <= '0;
				pos <= pos + 1'b1;
				if (pos == 2'd3)
					frame_req <= 1'b1;
			end else if (pos != 2'd0) begin
				gap_cnt <= gap_cnt + 1'b1;
				if (gap_cnt == GAP_LAST) begin
					gap_cnt <= '0;
					pos <= '0; // stale partial frame
				end
			end
		end
	end

	// new bytes enter at the top, byte 0 ends up lowest
	always_ff @(posedge clk) begin
		if (take)
			frame_bits <= {beat.data, frame_bits[31:8]};
	end

	a_frame_stable: assert property (@(posedge clk) disable iff (!nrst)
		frame_req && !frame_ack |=> $stable(frame));

endmodule

`default_nettype wire

// File: source/cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module cmd_engine (
	input  logic                                clk,
	input  logic                                nrst,
	input  logic                                frame_req,
	input  cmd_pkg::cmd_frame_u                 frame,
	output logic                                frame_ack,
	input  uart_pkg::uart_byte_t [`N_CH-1:0]    vctr_in,
	output uart_pkg::uart_byte_t [`N_CH-1:0]    vctr_out,
	output cmd_pkg::trig_cfg_t [`N_CH-1:0]      trig_cfg,
	output logic [`N_CH-1:0]                    fire,
	output logic                                tx_req,
	output uart_pkg::uart_byte_t                tx_byte,
	input  logic                                tx_ack
);
	import uart_pkg::*;
	import cmd_pkg::*;

	localparam int CHW = $clog2(`N_CH);

	logic take, cmd_ok, mode_ok, busy;
	logic [CHW-1:0] ch;
	logic [1:0] tx_left; // bytes still to go after the current one
	logic [31:0] reply;
	uart_byte_t rep_b2, rep_b3;

	assign take = frame_req && !frame_ack && !busy; // held off while replying
	assign ch = frame.vec.ch[CHW-1:0];
	assign mode_ok = frame.trig.mode == 8'd1 || frame.trig.mode == 8'd2;
	assign tx_byte = reply[7:0];

	always_comb begin
		cmd_ok = frame.vec.ch < 8'(`N_CH);
		rep_b2 = 8'hFF;
		rep_b3 = 8'hFF;
		case (frame.vec.cmd)
			CMD_WR_VEC: rep_b2 = frame.vec.value;
			CMD_RD_VEC: rep_b2 = vctr_in[ch];
			CMD_SET_TRIG: begin
				rep_b2 = frame.trig.mode;
				rep_b3 = frame.trig.count;
			end
			CMD_FIRE: rep_b2 = 8'hFF;
			default: cmd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			frame_ack <= 1'b0;
			busy <= 1'b0;
			tx_req <= 1'b0;
			tx_left <= '0;
			fire <= '0;
			vctr_out <= '0;
			for (int i = 0; i < `N_CH; i++)
				trig_cfg[i] <= '{mode: TRIG_HIGH, count: 8'd0};
		end else begin
			fire <= '0;
			if (take) begin
				frame_ack <= 1'b1;
				if (cmd_ok) begin
					busy <= 1'b1;
					tx_left <= 2'd3;
					if (frame.vec.cmd == CMD_WR_VEC)
						vctr_out[ch] <= frame.vec.value;
					if (frame.trig.cmd == CMD_SET_TRIG && mode_ok)
						trig_cfg[ch] <= '{mode: trig_mode_e'(frame.trig.mode[1:0]),
							count: frame.trig.count};
					if (frame.trig.cmd == CMD_FIRE)
						fire[ch] <= 1'b1;
				end
			end else if (frame_ack && !frame_req) begin
				frame_ack <= 1'b0;
			end

			// walk the reply out, one handshake per byte
			if (busy && !tx_req && !tx_ack) begin
				tx_req <= 1'b1;
			end else if (tx_req && tx_ack) begin
				tx_req <= 1'b0;
				if (tx_left == 2'd0)
					busy <= 1'b0;
				else
					tx_left <= tx_left - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			reply <= {rep_b3, rep_b2, frame.vec.ch, frame.vec.cmd};
		else if (tx_req && tx_ack)
			reply <= {8'hFF, reply[31:8]};
	end

	a_fire_strobe: assert property (@(posedge clk) disable iff (!nrst)
		|fire |-> $onehot(fire) ##1 fire == '0);

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module uart_tx (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 tx_req,
	input  uart_pkg::uart_byte_t tx_byte,
	output logic                 tx_ack,
	output logic                 txd
);
	localparam int CW = $clog2(`CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(`CLKS_PER_BIT - 1);

	logic sending, load, bit_end;
	logic [CW-1:0] clk_cnt;
	logic [3:0] bit_cnt;
	logic [8:0] shreg; // data bits then stop bit

	assign load = !sending && tx_req && !tx_ack;
	assign bit_end = sending && clk_cnt == BIT_LAST;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			txd <= 1'b1;
			tx_ack <= 1'b0;
			sending <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			if (load) begin
				sending <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
				txd <= 1'b0; // start bit
			end else if (sending) begin
				clk_cnt <= clk_cnt + 1'b1;
				if (bit_end) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 1'b1;
					txd <= shreg[0];
					if (bit_cnt == 4'd9) begin
						sending <= 1'b0;
						tx_ack <= 1'b1;
					end
				end
			end else if (tx_ack && !tx_req) begin
				tx_ack <= 1'b0;
			end
		end
	end

	// ones fill in behind so the line rests high
	always_ff @(posedge clk) begin
		if (load)
			shreg <= {1'b1, tx_byte};
		else if (bit_end)
			shreg <= {1'b1, shreg[8:1]};
	end

	a_ack_follows_req: assert property (@(posedge clk) disable iff (!nrst)
		tx_ack |-> $past(tx_req) || $past(tx_ack));

endmodule

`default_nettype wire

// File: source/trig_pulser.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module trig_pulser (
	input  logic               clk,
	input  logic               nrst,
	input  cmd_pkg::trig_cfg_t cfg,
	input  logic               fire,
	output logic               trigout
);
	import cmd_pkg::*;

	localparam int PMAX = (`PULSE_ON_CLKS > `PULSE_OFF_CLKS) ? `PULSE_ON_CLKS : `PULSE_OFF_CLKS;
	localparam int PW = $clog2(PMAX);
	localparam logic [PW-1:0] ON_LAST  = PW'(`PULSE_ON_CLKS - 1);
	localparam logic [PW-1:0] OFF_LAST = PW'(`PULSE_OFF_CLKS - 1);

	logic busy, on_phase, pol_low;
	logic [7:0] left;
	logic [PW-1:0] timer;

	// polarity is frozen for the whole train
	assign trigout = busy ? (on_phase ^ pol_low) : (cfg.mode == TRIG_LOW);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			busy <= 1'b0;
			on_phase <= 1'b0;
			pol_low <= 1'b0;
			left <= '0;
			timer <= '0;
		end else if (!busy) begin
			if (fire && cfg.count != 8'd0) begin
				busy <= 1'b1;
				on_phase <= 1'b1;
				pol_low <= cfg.mode == TRIG_LOW;
				left <= cfg.count;
				timer <= '0;
			end
		end else if (on_phase) begin
			timer <= timer + 1'b1;
			if (timer == ON_LAST) begin
				timer <= '0;
				on_phase <= 1'b0;
			end
		end else begin
			timer <= timer + 1'b1;
			if (timer == OFF_LAST) begin
				timer <= '0;
				if (left == 8'd1) begin
					busy <= 1'b0; // last off phase done
				end else begin
					left <= left - 1'b1;
					on_phase <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/mlc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module mlc_top (
	input  logic                             clk,
	input  logic                             nrst,
	input  logic                             rxd,
	output logic                             txd,
	input  uart_pkg::uart_byte_t [`N_CH-1:0] vctr_in,
	output uart_pkg::uart_byte_t [`N_CH-1:0] vctr_out,
	output logic [`N_CH-1:0]                 trigout
);
	import uart_pkg::*;
	import cmd_pkg::*;

	rx_beat_t beat;
	cmd_frame_u frame;
	logic frame_req, frame_ack;
	trig_cfg_t [`N_CH-1:0] trig_cfg;
	logic [`N_CH-1:0] fire;
	logic tx_req, tx_ack;
	uart_byte_t tx_byte;

	uart_rx u_rx (.clk, .nrst, .rxd, .beat);

	frame_assembler u_asm (.clk, .nrst, .beat, .frame_req, .frame, .frame_ack);

	cmd_engine u_eng (
		.clk, .nrst, .frame_req, .frame, .frame_ack,
		.vctr_in, .vctr_out, .trig_cfg, .fire,
		.tx_req, .tx_byte, .tx_ack
	);

	uart_tx u_tx (.clk, .nrst, .tx_req, .tx_byte, .tx_ack, .txd);

	// one pulser per channel
	for (genvar g = 0; g < `N_CH; g++) begin : g_ch
		trig_pulser u_pulser (
			.clk, .nrst, .cfg(trig_cfg[g]), .fire(fire[g]), .trigout(trigout[g])
		);
	end

endmodule

`default_nettype wire

// File: tb/tb_mlc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlc_defines.svh"

module tb_mlc_top;
	import uart_pkg::*;
	import cmd_pkg::*;

	localparam int unsigned SEED = 32'h23e90c71;
	localparam int CPB = `CLKS_PER_BIT;
	localparam int TRAIN_CLKS = `PULSE_ON_CLKS + `PULSE_OFF_CLKS;
	localparam int N_FRAMES = 14;
	localparam int TIMEOUT = N_FRAMES * 80 * CPB + 255 * TRAIN_CLKS + 4000;

	logic clk, nrst, rxd, txd;
	uart_byte_t [`N_CH-1:0] vctr_in, vctr_out, exp_vout;
	logic [`N_CH-1:0] trigout, idle_lvl;
	logic armed; // pulse counting window
	logic [7:0] replies[$];
	int rd_ptr, checks, errors, width_err, frame_err, sva_err, cycles;
	int edges[`N_CH];
	int width[`N_CH];

	mlc_top uut (.clk, .nrst, .rxd, .txd, .vctr_in, .vctr_out, .trigout);

	always #20 clk = ~clk;

	a_reset_state: assert property (@(posedge clk)
		$rose(nrst) |-> txd && trigout == '0 && vctr_out == '0)
		else begin
			sva_err = sva_err + 1;
			$display("FAIL t=%0t txd/trigout/vctr_out expected 1/0/0 got %b/%h/%h",
				$time, txd, trigout, vctr_out);
		end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT) begin
			$display("run stopped, cycle limit %0d reached", TIMEOUT);
			$display("checks %0d, errors %0d", checks, errors + width_err + frame_err + sva_err);
			$display(">>> FAIL");
			$finish;
		end
	end

	// reply bytes off txd, sampled mid-bit
	initial begin : txd_monitor
		logic [7:0] b;
		forever begin
			@(posedge clk);
			if (nrst && !txd) begin
				repeat (CPB / 2) @(posedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (CPB) @(posedge clk);
					b[i] = txd;
				end
				repeat (CPB) @(posedge clk);
				assert (txd) else begin
					frame_err = frame_err + 1;
					$display("FAIL t=%0t txd stop bit expected 1 got 0", $time);
				end
				replies.push_back(b);
			end
		end
	end

	// active = away from idle level
	always @(posedge clk) begin
		logic act;
		for (int g = 0; g < `N_CH; g++) begin
			act = trigout[g] ^ idle_lvl[g];
			if (!armed) begin
				edges[g] = 0;
				width[g] = 0;
			end else if (act) begin
				if (width[g] == 0)
					edges[g] = edges[g] + 1;
				width[g] = width[g] + 1;
			end else if (width[g] != 0) begin
				assert (width[g] == `PULSE_ON_CLKS) else begin
					width_err = width_err + 1;
					$display("FAIL t=%0t trigout[%0d] active cycles expected %0d got %0d",
						$time, g, `PULSE_ON_CLKS, width[g]);
				end
				width[g] = 0;
			end
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		checks++;
		assert (exp_v == got_v) else begin
			errors++;
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd <= bits[i];
			repeat (CPB) @(posedge clk);
		end
	endtask

	task automatic send_frame(input logic [7:0] c, input logic [7:0] ch,
		input logic [7:0] b2, input logic [7:0] b3);
		send_byte(c);
		send_byte(ch);
		send_byte(b2);
		send_byte(b3);
	endtask

	// byte 0 of the reply in the low bits
	task automatic expect_reply(input string what, input logic [31:0] exp_w);
		int waited;
		logic [31:0] got;
		waited = 0;
		while (replies.size() < rd_ptr + 4 && waited < 60 * CPB) begin
			@(posedge clk);
			waited++;
		end
		if (replies.size() < rd_ptr + 4) begin
			errors++;
			$display("no complete reply to %s within %0d cycles", what, 60 * CPB);
		end else begin
			got = {replies[rd_ptr+3], replies[rd_ptr+2], replies[rd_ptr+1], replies[rd_ptr]};
			rd_ptr += 4;
			check_val(what, exp_w, got);
		end
	endtask

	task automatic expect_quiet(input string what, input int clks);
		repeat (clks) @(posedge clk);
		check_val({what, " reply bytes"}, rd_ptr, replies.size());
	endtask

	task automatic run_train(input int ch, input int n);
		armed <= 1'b1;
		@(posedge clk);
		send_frame(CMD_FIRE, 8'(ch), 8'($urandom), 8'($urandom));
		expect_reply("fire reply", {16'hFFFF, 8'(ch), CMD_FIRE});
		repeat (n * TRAIN_CLKS + 2) @(posedge clk);
		@(negedge clk);
		for (int g = 0; g < `N_CH; g++)
			check_val($sformatf("edges on trigout[%0d]", g), (g == ch) ? n : 0, edges[g]);
		check_val("trigout", 32'(idle_lvl), 32'(trigout));
		@(posedge clk);
		armed <= 1'b0;
	endtask

	initial begin
		int ch, ch_lo, n, bad_ch;
		logic [7:0] val;
		void'($urandom(SEED));
		clk = 1'b0;
		nrst = 1'b0;
		rxd = 1'b1;
		armed = 1'b0;
		idle_lvl = '0;
		exp_vout = '0;
		for (int i = 0; i < `N_CH; i++)
			vctr_in[i] = 8'($urandom);
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		repeat (2) @(negedge clk);
		check_val("txd", 1, 32'(txd));
		check_val("trigout", 0, 32'(trigout));
		check_val("vctr_out", 0, vctr_out);
		@(posedge clk);

		ch = int'($urandom % `N_CH);
		val = 8'($urandom);
		send_frame(CMD_WR_VEC, 8'(ch), val, 8'($urandom));
		exp_vout[ch] = val;
		expect_reply("wr_vec reply", {8'hFF, val, 8'(ch), CMD_WR_VEC});
		check_val("vctr_out", exp_vout, vctr_out);

		ch = int'($urandom % `N_CH);
		send_frame(CMD_RD_VEC, 8'(ch), 8'($urandom), 8'($urandom));
		expect_reply("rd_vec reply", {8'hFF, vctr_in[ch], 8'(ch), CMD_RD_VEC});

		// high pulses on one channel
		ch = int'($urandom % `N_CH);
		n = 1 + int'($urandom % 6);
		send_frame(CMD_SET_TRIG, 8'(ch), 8'd1, 8'(n));
		expect_reply("set_trig reply", {8'(n), 8'd1, 8'(ch), CMD_SET_TRIG});
		run_train(ch, n);

		// low pulses on the next one, then an empty train
		ch_lo = (ch + 1) % `N_CH;
		n = 1 + int'($urandom % 6);
		send_frame(CMD_SET_TRIG, 8'(ch_lo), 8'd2, 8'(n));
		expect_reply("set_trig reply", {8'(n), 8'd2, 8'(ch_lo), CMD_SET_TRIG});
		@(negedge clk);
		check_val("idle trigout", 1, 32'(trigout[ch_lo]));
		@(posedge clk);
		idle_lvl[ch_lo] <= 1'b1;
		run_train(ch_lo, n);
		send_frame(CMD_SET_TRIG, 8'(ch_lo), 8'd2, 8'd0);
		expect_reply("set_trig reply", {8'd0, 8'd2, 8'(ch_lo), CMD_SET_TRIG});
		run_train(ch_lo, 0);

		send_frame(8'h11, 8'd0, 8'h5A, 8'h5A);
		expect_quiet("unknown command", 50 * CPB);
		bad_ch = 4 + int'($urandom % 252);
		send_frame(CMD_WR_VEC, 8'(bad_ch), 8'($urandom), 8'hFF);
		expect_quiet("channel out of range", 50 * CPB);
		check_val("vctr_out", exp_vout, vctr_out);
		check_val("trigout", 32'(idle_lvl), 32'(trigout));

		// stray byte must age out before the next frame
		send_byte(CMD_WR_VEC);
		repeat ((`FRAME_GAP_BITS + 5) * CPB) @(posedge clk);
		ch = int'($urandom % `N_CH);
		val = 8'($urandom);
		send_frame(CMD_WR_VEC, 8'(ch), val, 8'($urandom));
		exp_vout[ch] = val;
		expect_reply("wr_vec after gap", {8'hFF, val, 8'(ch), CMD_WR_VEC});
		check_val("vctr_out", exp_vout, vctr_out);

		$display("checks %0d, value errors %0d, width errors %0d, framing errors %0d, %s %0d",
			checks, errors, width_err, frame_err, "reset assertion errors", sva_err);
		if (errors + width_err + frame_err + sva_err == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/uart_pkg.sv
source/cmd_pkg.sv
source/uart_rx.sv
source/frame_assembler.sv
source/cmd_engine.sv
source/uart_tx.sv
source/trig_pulser.sv
source/mlc_top.sv
tb/tb_mlc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_mlc_top -o sim_mlc
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_mlc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx ">>> PASS" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
